// File: logic/lenet_pkg.sv
package lenet_pkg;

    localparam int PIX_W  = 8;
    localparam int PROD_W = 16;
    localparam int ACC_W  = 24;  // Holds a full 5x5 window of 16-bit products with room to spare.

    typedef logic [PIX_W-1:0]  pix_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic signed [15:0] bias_t;
    typedef logic [2:0]        shift_t;

    // Addresses 0 and up select kernel weights in row-major order.
    localparam logic [4:0] CFG_BIAS_ADDR  = 5'd30;
    localparam logic [4:0] CFG_SHIFT_ADDR = 5'd31;

endpackage

// File: logic/approx_mul8.sv
`timescale 1ns/1ps

module approx_mul8 (
    input  lenet_pkg::pix_t  x,
    input  lenet_pkg::pix_t  y,
    output lenet_pkg::prod_t z
);
    import lenet_pkg::*;

    pix_t        pp [PIX_W];  // Partial product of y for each bit of x.
    logic [12:0] np [6];      // Compressed terms built from partial products 0 to 5.
    prod_t       total;

    always_comb begin
        for (int i = 0; i < PIX_W; i++) begin
            pp[i] = y & {PIX_W{x[i]}};
        end
    end

    // Each compressed bit merges two neighbouring partial-product bits of equal weight.
    // Any bit of rows 0 to 5 that is not listed below is dropped.
    always_comb begin
        for (int k = 0; k < 6; k++) begin
            np[k] = '0;
        end

        np[0][2]  = pp[0][2] | pp[1][1];
        np[0][4]  = pp[0][4] & pp[1][3];
        np[0][5]  = pp[2][3] & pp[3][2];
        np[0][6]  = pp[4][1] ^ pp[5][0];
        np[0][7]  = pp[0][7] & pp[1][6];
        np[0][8]  = pp[0][7] | pp[1][6];
        np[0][9]  = pp[2][7] ^ pp[3][6];
        np[0][10] = pp[2][7] & pp[3][6];
        np[0][11] = pp[4][6] & pp[5][5];
        np[0][12] = pp[5][7];

        np[1][4]  = pp[0][4] | pp[1][3];
        np[1][5]  = pp[4][1] & pp[5][0];
        np[1][7]  = pp[4][2] | pp[5][1];
        np[1][8]  = pp[2][5] ^ pp[3][4];
        np[1][9]  = pp[4][5] ^ pp[5][4];
        np[1][10] = pp[3][7];
        np[1][11] = pp[4][7] & pp[5][6];

        np[2][7]  = pp[4][3] | pp[5][2];
        np[2][8]  = pp[2][6] & pp[3][5];
        np[2][10] = pp[4][5] & pp[5][4];
        np[2][11] = pp[4][7] | pp[5][6];

        np[3][8]  = pp[2][6] | pp[3][5];
        np[3][10] = pp[4][6] ^ pp[5][5];

        np[4][8]  = pp[4][4] & pp[5][3];

        np[5][8]  = pp[4][4] | pp[5][3];
    end

    // The two top rows are added exactly, which keeps pixels of 64 and 128 exact.
    always_comb begin
        total = prod_t'({pp[6], 6'b0}) + prod_t'({pp[7], 7'b0});
        for (int k = 0; k < 6; k++) begin
            total = total + prod_t'(np[k]);
        end
    end

    assign z = total;

endmodule

// File: logic/kernel_if.sv
`timescale 1ns/1ps

interface kernel_if #(parameter int KERNEL_K = 5);
    import lenet_pkg::*;

    logic [$clog2(KERNEL_K)-1:0] row_sel;
    pix_t                        row_weights [KERNEL_K];  // Follows row_sel in the same cycle.
    bias_t                       bias;
    shift_t                      shift;

    modport bank (
        input  row_sel,
        output row_weights, bias, shift
    );

    modport datapath (
        output row_sel,
        input  row_weights
    );

    modport post (
        input bias, shift
    );

endinterface

// File: logic/weight_bank.sv
`timescale 1ns/1ps

module weight_bank #(
    parameter int KERNEL_K = 5
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_write,
    input  logic [4:0]  cfg_addr,
    input  logic [15:0] cfg_data,
    kernel_if.bank      kif
);
    import lenet_pkg::*;

    localparam int NUM_W = KERNEL_K * KERNEL_K;

    pix_t   weights [NUM_W];
    bias_t  bias_q;
    shift_t shift_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_W; i++) begin
                weights[i] <= '0;
            end
            bias_q  <= '0;
            shift_q <= '0;
        end else if (cfg_write) begin
            for (int i = 0; i < NUM_W; i++) begin
                if (cfg_addr == 5'(i)) weights[i] <= cfg_data[PIX_W-1:0];
            end
            if (cfg_addr == CFG_BIAS_ADDR) bias_q <= bias_t'(cfg_data);
            if (cfg_addr == CFG_SHIFT_ADDR) shift_q <= cfg_data[2:0];  // Other addresses are ignored.
        end
    end

    always_comb begin
        for (int c = 0; c < KERNEL_K; c++) begin
            kif.row_weights[c] = weights[int'(kif.row_sel) * KERNEL_K + c];
        end
    end

    assign kif.bias  = bias_q;
    assign kif.shift = shift_q;

endmodule

// File: logic/window_mac.sv
`timescale 1ns/1ps

module window_mac #(
    parameter int KERNEL_K = 5
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              row_valid,
    input  lenet_pkg::pix_t   row_pixels [KERNEL_K],
    kernel_if.datapath        kif,
    output logic              sum_valid,
    output lenet_pkg::acc_t   sum
);
    import lenet_pkg::*;

    localparam int ROW_W = $clog2(KERNEL_K);

    pix_t             pix_q [KERNEL_K];
    logic             pix_valid;
    logic [ROW_W-1:0] row_cnt;  // Index of the row now held in pix_q.
    logic             last_row;
    prod_t            prod [KERNEL_K];
    prod_t            prod_q [KERNEL_K];
    logic             prod_valid;
    logic             prod_last;
    acc_t             row_total;
    acc_t             acc;

    assign kif.row_sel = row_cnt;
    assign last_row    = (row_cnt == ROW_W'(KERNEL_K - 1));

    always_ff @(posedge clk) begin
        if (row_valid) pix_q <= row_pixels;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
            row_cnt   <= '0;
        end else begin
            pix_valid <= row_valid;
            if (pix_valid) row_cnt <= last_row ? '0 : row_cnt + 1'b1;
        end
    end

    for (genvar c = 0; c < KERNEL_K; c++) begin : g_mul
        approx_mul8 mul0 (
            .x (pix_q[c]),
            .y (kif.row_weights[c]),
            .z (prod[c])
        );
    end

    always_ff @(posedge clk) begin
        if (pix_valid) prod_q <= prod;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= pix_valid;
            prod_last  <= pix_valid && last_row;
        end
    end

    always_comb begin
        row_total = '0;
        for (int c = 0; c < KERNEL_K; c++) begin
            row_total = row_total + acc_t'(prod_q[c]);
        end
    end

    // The last row hands the window total to the output and starts the next window from zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            sum       <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid && prod_last;
            if (prod_valid) begin
                if (prod_last) begin
                    sum <= acc + row_total;
                    acc <= '0;
                end else begin
                    acc <= acc + row_total;
                end
            end
        end
    end

endmodule

// File: logic/relu_requant.sv
`timescale 1ns/1ps

module relu_requant (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sum_valid,
    input  lenet_pkg::acc_t sum,
    kernel_if.post          kif,
    output logic            result_valid,
    output lenet_pkg::pix_t result
);
    import lenet_pkg::*;

    localparam int BIASED_W = ACC_W + 2;  // Sign bit plus one bit of carry.

    logic signed [BIASED_W-1:0] biased;
    logic [BIASED_W-1:0]        shifted;
    pix_t                       clamped;

    always_comb begin
        biased = $signed({2'b00, sum}) + BIASED_W'(kif.bias);
        if (biased < 0) begin
            shifted = '0;  // ReLU.
        end else begin
            shifted = biased >> kif.shift;
        end
        clamped = (|shifted[BIASED_W-1:PIX_W]) ? '1 : shifted[PIX_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) result_valid <= 1'b0;
        else        result_valid <= sum_valid;
    end

    always_ff @(posedge clk) begin
        if (sum_valid) result <= clamped;
    end

endmodule

// File: logic/lenet_conv_unit.sv
`timescale 1ns/1ps

module lenet_conv_unit #(
    parameter int KERNEL_K = 5
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_write,
    input  logic [4:0]      cfg_addr,
    input  logic [15:0]     cfg_data,
    input  logic            row_valid,
    input  lenet_pkg::pix_t row_pixels [KERNEL_K],
    output logic            result_valid,
    output lenet_pkg::pix_t result
);
    import lenet_pkg::*;

    logic sum_valid;
    acc_t sum;  // Window total before bias and requantization.

    kernel_if #(.KERNEL_K(KERNEL_K)) kif0 ();

    weight_bank #(.KERNEL_K(KERNEL_K)) bank0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .kif       (kif0.bank)
    );

    window_mac #(.KERNEL_K(KERNEL_K)) mac0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_valid  (row_valid),
        .row_pixels (row_pixels),
        .kif        (kif0.datapath),
        .sum_valid  (sum_valid),
        .sum        (sum)
    );

    relu_requant post0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sum_valid    (sum_valid),
        .sum          (sum),
        .kif          (kif0.post),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: tests/lenet_conv_unit_assertions.sv
`timescale 1ns/1ps

module lenet_conv_unit_assertions (
    input logic clk,
    input logic rst_n,
    input logic cfg_write,
    input logic row_valid,
    input logic result_valid,
    input logic [7:0] result
);

    a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else $error("result_valid high during reset");

    // A window takes at least two rows, so results are never adjacent.
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else $error("result_valid high on two consecutive cycles");

    a_known_result: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> !$isunknown(result))
        else $error("result unknown while result_valid is high");

    a_cfg_row_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(cfg_write && row_valid))
        else $error("cfg_write and row_valid high together");

endmodule

bind lenet_conv_unit lenet_conv_unit_assertions asrt0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_write    (cfg_write),
    .row_valid    (row_valid),
    .result_valid (result_valid),
    .result       (result)
);

// File: tests/lenet_conv_unit_tb.sv
`timescale 1ns/1ps

module lenet_conv_unit_tb;
    import lenet_pkg::*;

    localparam int KERNEL_K       = 5;
    localparam int LATENCY        = 3;
    localparam int TIMEOUT_CYCLES = 200;

    logic        clk;
    logic        rst_n;
    logic        cfg_write;
    logic [4:0]  cfg_addr;
    logic [15:0] cfg_data;
    logic        row_valid;
    pix_t        row_pixels [KERNEL_K];
    logic        result_valid;
    pix_t        result;

    int   cycle;
    int   value_errors;
    int   timeout_errors;
    int   checked;
    int   rows_sent;
    pix_t exp_q [$];  // Expected result of each window in flight.
    int   due_q [$];  // Cycle at which that result must appear.

    lenet_conv_unit #(.KERNEL_K(KERNEL_K)) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .row_valid    (row_valid),
        .row_pixels   (row_pixels),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Outputs are sampled on the falling edge, half a cycle after they settle.
    always @(negedge clk) begin
        if (result_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: result_valid high with no window pending", $time);
                value_errors++;
            end else begin
                if (cycle != due_q[0]) begin
                    $display("ERROR at %0t: result at cycle %0d, expected cycle %0d",
                             $time, cycle, due_q[0]);
                    value_errors++;
                end
                if (result !== exp_q[0]) begin
                    $display("ERROR at %0t: result %0h, expected %0h", $time, result, exp_q[0]);
                    value_errors++;
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                checked++;
            end
        end else if (due_q.size() != 0 && cycle > due_q[0]) begin
            $display("Timeout: no result arrived for the window due at cycle %0d", due_q[0]);
            timeout_errors++;
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results still missing after %0d cycles",
                     exp_q.size(), TIMEOUT_CYCLES);
            timeout_errors++;
        end
    endtask

    task automatic write_cfg(input logic [4:0] addr, input logic [15:0] data);
        wait_drained();  // The pipeline must be empty before the kernel changes.
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    task automatic send_row(input logic [31:0] pix [KERNEL_K], input pix_t expected);
        for (int c = 0; c < KERNEL_K; c++) begin
            row_pixels[c] = pix[c][PIX_W-1:0];
        end
        row_valid = 1'b1;
        rows_sent++;
        if (rows_sent % KERNEL_K == 0) begin
            exp_q.push_back(expected);
            due_q.push_back(cycle + 1 + LATENCY);  // Sampled on the next rising edge.
        end
        @(negedge clk);
        row_valid = 1'b0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          gap_mode;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] pix [KERNEL_K];
        pix_t        next_exp;

        void'($urandom(29774));
        cycle     = 0;
        rst_n     = 1'b0;
        cfg_write = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        row_valid = 1'b0;
        for (int c = 0; c < KERNEL_K; c++) begin
            row_pixels[c] = '0;
        end
        gap_mode = 0;
        next_exp = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle(10);  // No rows yet, so the checker must see result_valid stay low.

        fd = $fopen("tests/conv_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file tests/conv_patterns.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0) begin
                    case (line.getc(0))
                        "G": n = $sscanf(line, "G %d", gap_mode);
                        "E": n = $sscanf(line, "E %h", next_exp);
                        "C": begin
                            n = $sscanf(line, "C %h %h", a, d);
                            write_cfg(a[4:0], d[15:0]);
                        end
                        "R": begin
                            n = $sscanf(line, "R %h %h %h %h %h",
                                        pix[0], pix[1], pix[2], pix[3], pix[4]);
                            if (gap_mode != 0) idle($urandom_range(0, 3));
                            send_row(pix, next_exp);
                        end
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
            wait_drained();
            idle(5);
            $display("Checked %0d windows: %0d value errors, %0d timeouts",
                     checked, value_errors, timeout_errors);
            if (value_errors == 0 && timeout_errors == 0 && checked > 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

    initial begin
        #200000;
        $display("Timeout: the simulation ran past its time limit");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: tests/conv_patterns.txt
# C addr data: config write | E value: expected result of the next window | R p0..p4: pixel row
# G 0 sends rows back to back, G 1 adds random idle gaps. All numbers are hex.
G 0
E 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
C 00 0002
C 18 0001
E C0
R 40 00 80 00 00
R 00 80 00 40 00
R 00 00 80 00 00
R 80 00 00 00 00
R 00 00 00 00 40
E 84
R 03 55 AA 12 34
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 9C 00 00 00 7F
E FF
R FF 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 FF
G 1
C 1F 0002
E D1
R FF 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 FF
C 1F 0000
C 1E FC18
E 00
R FF 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 00
R 00 00 00 00 FF

// File: lenet_conv_unit.f
logic/lenet_pkg.sv
logic/approx_mul8.sv
logic/kernel_if.sv
logic/weight_bank.sv
logic/window_mac.sv
logic/relu_requant.sv
logic/lenet_conv_unit.sv
tests/lenet_conv_unit_assertions.sv
tests/lenet_conv_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lenet_conv_unit.f \
    --top-module lenet_conv_unit_tb -o lenet_conv_unit_sim
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

output=$(./obj_dir/lenet_conv_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "$output" | grep -q "TEST RESULT: PASS" || exit 1
exit 0
